//--- src/decode_pkg.sv
package decode_pkg;

    // Default program counter width of the core
    typedef logic [23:0] pc_t;

    // Immediate fields, one per encoding width
    typedef logic [9:0]  imm10_t;
    typedef logic [11:0] imm12_t;
    typedef logic [13:0] imm14_t;
    typedef logic [15:0] imm16_t;

    // Branch condition code
    typedef logic [3:0]  cc_t;

    // General-purpose register index, 16 registers
    typedef logic [3:0]  gp_idx_t;

    // Special-register index, 4 registers
    typedef logic [1:0]  sr_idx_t;

endpackage

//--- src/isa_pkg.sv
package isa_pkg;
    import decode_pkg::*;

    typedef logic [23:0] instr_t;
    typedef logic [7:0]  opc_t;
    typedef logic [3:0]  opclass_t;

    // Field positions inside an instruction word
    localparam int opc_lsb      = 16;
    localparam int opclass_lsb  = 20;
    localparam int tgt_gp_lsb   = 12;
    localparam int src_gp_lsb   = 8;
    localparam int tgt_sr_lsb   = 14;
    localparam int src_sr_lsb   = 12;
    localparam int cc_lsb_jcc   = 12;
    localparam int cc_lsb_bcc   = 8;
    localparam int cc_lsb_srjcc = 10;
    localparam int cc_lsb_mcc   = 4;

    // Opcode classes, upper nibble of the opcode
    localparam opclass_t opclass_ur = 4'h0;
    localparam opclass_t opclass_ui = 4'h1;
    localparam opclass_t opclass_sr = 4'h2;
    localparam opclass_t opclass_si = 4'h3;
    localparam opclass_t opclass_br = 4'h7;
    localparam opclass_t opclass_sp = 4'hf;

    // Unsigned register ALU
    localparam opc_t opc_mov_ur = 8'h00;
    localparam opc_t opc_add_ur = 8'h01;
    localparam opc_t opc_sub_ur = 8'h02;
    localparam opc_t opc_not_ur = 8'h03;
    localparam opc_t opc_and_ur = 8'h04;
    localparam opc_t opc_or_ur  = 8'h05;
    localparam opc_t opc_xor_ur = 8'h06;
    localparam opc_t opc_shl_ur = 8'h07;
    localparam opc_t opc_shr_ur = 8'h08;
    localparam opc_t opc_rol_ur = 8'h09;
    localparam opc_t opc_ror_ur = 8'h0a;
    localparam opc_t opc_cmp_ur = 8'h0b;
    localparam opc_t opc_tst_ur = 8'h0c;

    // Unsigned immediate ALU
    localparam opc_t opc_mov_ui = 8'h10;
    localparam opc_t opc_add_ui = 8'h11;
    localparam opc_t opc_sub_ui = 8'h12;
    localparam opc_t opc_and_ui = 8'h13;
    localparam opc_t opc_or_ui  = 8'h14;
    localparam opc_t opc_xor_ui = 8'h15;
    localparam opc_t opc_shl_ui = 8'h16;
    localparam opc_t opc_shr_ui = 8'h17;
    localparam opc_t opc_rol_ui = 8'h18;
    localparam opc_t opc_ror_ui = 8'h19;
    localparam opc_t opc_cmp_ui = 8'h1a;
    localparam opc_t opc_lui_ui = 8'h1b;

    // Signed register ALU
    localparam opc_t opc_add_sr = 8'h20;
    localparam opc_t opc_sub_sr = 8'h21;
    localparam opc_t opc_shr_sr = 8'h22;
    localparam opc_t opc_neg_sr = 8'h23;
    localparam opc_t opc_cmp_sr = 8'h24;
    localparam opc_t opc_tst_sr = 8'h25;

    // Signed immediate ALU
    localparam opc_t opc_mov_si = 8'h30;
    localparam opc_t opc_add_si = 8'h31;
    localparam opc_t opc_sub_si = 8'h32;
    localparam opc_t opc_shr_si = 8'h33;
    localparam opc_t opc_cmp_si = 8'h34;

    // Branches and conditional moves
    localparam opc_t opc_jcc_ui = 8'h70;
    localparam opc_t opc_bcc_sr = 8'h71;
    localparam opc_t opc_bcc_so = 8'h72;
    localparam opc_t opc_bal_so = 8'h73;
    localparam opc_t opc_mcc_ur = 8'h74;
    localparam opc_t opc_mcc_si = 8'h75;

    // Special-register operations, system call and kernel return
    localparam opc_t opc_sr_mov_ur = 8'hf0;
    localparam opc_t opc_sr_jcc_so = 8'hf1;
    localparam opc_t opc_sr_add_si = 8'hf2;
    localparam opc_t opc_sr_sub_si = 8'hf3;
    localparam opc_t opc_sr_st_so  = 8'hf4;
    localparam opc_t opc_sr_ld_so  = 8'hf5;
    localparam opc_t opc_syscall   = 8'hf6;
    localparam opc_t opc_kret      = 8'hf7;

    // Fixed special registers
    localparam sr_idx_t sr_idx_lr = 2'd1;
    localparam sr_idx_t sr_idx_fl = 2'd2;

    function automatic opc_t instr_opc(instr_t instr);
        return instr[opc_lsb +: $bits(opc_t)];
    endfunction

    function automatic opclass_t instr_opclass(instr_t instr);
        return instr[opclass_lsb +: $bits(opclass_t)];
    endfunction

endpackage

//--- src/id_opcode_classify.sv
`timescale 1ns/1ps

module id_opcode_classify
    import isa_pkg::*;
(
    input  instr_t instr,
    output logic   sgn_en,
    output logic   imm_en,
    output logic   has_src_gp,
    output logic   has_tgt_gp,
    output logic   tgt_gp_we,
    output logic   has_src_sr,
    output logic   has_tgt_sr,
    output logic   tgt_sr_we,
    output logic   uses_flags
);

    opc_t     opc;
    opclass_t opclass;

    logic is_ur;
    logic is_ui;
    logic is_sr;
    logic is_si;
    logic is_br;
    logic is_alu;
    logic is_cmp_tst;
    logic is_sp_imm;
    logic is_imm_branch;

    assign opc     = instr_opc(instr);
    assign opclass = instr_opclass(instr);

    // Class decode
    assign is_ur  = (opclass == opclass_ur);
    assign is_ui  = (opclass == opclass_ui);
    assign is_sr  = (opclass == opclass_sr);
    assign is_si  = (opclass == opclass_si);
    assign is_br  = (opclass == opclass_br);
    assign is_alu = is_ur | is_ui | is_sr | is_si;

    // Compares and tests name a target but never write it
    assign is_cmp_tst = opc inside {opc_cmp_ur, opc_tst_ur, opc_cmp_ui,
                                    opc_cmp_sr, opc_tst_sr, opc_cmp_si};

    // SR operations that carry a signed offset or addend
    assign is_sp_imm = opc inside {opc_sr_jcc_so, opc_sr_add_si, opc_sr_sub_si,
                                   opc_sr_st_so, opc_sr_ld_so};

    // Branches with an immediate target or offset
    assign is_imm_branch = opc inside {opc_jcc_ui, opc_bcc_so, opc_bal_so};

    // Every branch-class op reads FL, as does the SR-relative jump
    assign uses_flags = is_br | (opc == opc_sr_jcc_so);

    assign sgn_en = is_sr | is_si | is_sp_imm |
                    (opc inside {opc_bcc_sr, opc_bcc_so, opc_bal_so});

    assign imm_en = is_ui | is_si | is_imm_branch | is_sp_imm |
                    (opc == opc_syscall);

    // GP register usage
    assign tgt_gp_we  = (is_alu & ~is_cmp_tst) |
                        (opc == opc_mcc_ur) | (opc == opc_mcc_si);
    assign has_tgt_gp = tgt_gp_we | is_cmp_tst | (opc == opc_bcc_sr);
    assign has_src_gp = (is_ur & (opc != opc_not_ur) & (opc != opc_tst_ur)) |
                        (opc inside {opc_add_sr, opc_sub_sr, opc_shr_sr, opc_cmp_sr}) |
                        (opc == opc_mcc_ur);

    // SR register usage, syscall writes the link register
    assign tgt_sr_we  = opc inside {opc_sr_mov_ur, opc_sr_add_si, opc_sr_sub_si,
                                    opc_sr_ld_so, opc_syscall};
    assign has_tgt_sr = tgt_sr_we | (opc == opc_sr_st_so);
    assign has_src_sr = uses_flags |
                        (opc inside {opc_sr_mov_ur, opc_sr_jcc_so, opc_sr_ld_so,
                                     opc_sr_st_so});

endmodule

//--- src/id_field_extract.sv
`timescale 1ns/1ps

module id_field_extract
    import isa_pkg::*;
    import decode_pkg::*;
(
    input  instr_t  instr,
    input  logic    has_src_gp,
    input  logic    has_tgt_gp,
    input  logic    has_src_sr,
    input  logic    has_tgt_sr,
    input  logic    uses_flags,
    output imm10_t  imm10,
    output imm12_t  imm12,
    output imm14_t  imm14,
    output imm16_t  imm16,
    output cc_t     cc,
    output gp_idx_t src_gp,
    output gp_idx_t tgt_gp,
    output sr_idx_t src_sr,
    output sr_idx_t tgt_sr
);

    opc_t     opc;
    opclass_t opclass;

    logic sel_imm10;
    logic sel_imm12;
    logic sel_imm14;
    logic sel_imm16;

    assign opc     = instr_opc(instr);
    assign opclass = instr_opclass(instr);

    // Immediate width per opcode, at most one is selected
    assign sel_imm12 = (opclass == opclass_ui) || (opclass == opclass_si) ||
                       (opc inside {opc_jcc_ui, opc_bcc_so, opc_sr_st_so,
                                    opc_sr_ld_so, opc_syscall});
    assign sel_imm14 = opc inside {opc_sr_add_si, opc_sr_sub_si};
    assign sel_imm10 = (opc == opc_sr_jcc_so);
    assign sel_imm16 = (opc == opc_bal_so);

    // Immediates sit at the bottom of the word
    assign imm10 = sel_imm10 ? instr[$bits(imm10_t)-1:0] : '0;
    assign imm12 = sel_imm12 ? instr[$bits(imm12_t)-1:0] : '0;
    assign imm14 = sel_imm14 ? instr[$bits(imm14_t)-1:0] : '0;
    assign imm16 = sel_imm16 ? instr[$bits(imm16_t)-1:0] : '0;

    // Condition code position depends on the branch encoding
    always_comb begin
        case (opc)
            opc_jcc_ui, opc_bcc_so: begin
                cc = instr[cc_lsb_jcc +: $bits(cc_t)];
            end
            opc_bcc_sr, opc_mcc_si: begin
                cc = instr[cc_lsb_bcc +: $bits(cc_t)];
            end
            opc_sr_jcc_so: begin
                cc = instr[cc_lsb_srjcc +: $bits(cc_t)];
            end
            opc_mcc_ur: begin
                cc = instr[cc_lsb_mcc +: $bits(cc_t)];
            end
            default: begin
                cc = '0;
            end
        endcase
    end

    // GP indices only when the classifier says the field is present
    assign tgt_gp = has_tgt_gp ? instr[tgt_gp_lsb +: $bits(gp_idx_t)] : '0;
    assign src_gp = has_src_gp ? instr[src_gp_lsb +: $bits(gp_idx_t)] : '0;

    // Syscall and kret always target LR
    always_comb begin
        if ((opc == opc_syscall) || (opc == opc_kret)) begin
            tgt_sr = sr_idx_lr;
        end else if (has_tgt_sr) begin
            tgt_sr = instr[tgt_sr_lsb +: $bits(sr_idx_t)];
        end else begin
            tgt_sr = '0;
        end
    end

    // Flag consumers read FL regardless of the encoded field
    always_comb begin
        if (uses_flags) begin
            src_sr = sr_idx_fl;
        end else if (has_src_sr) begin
            src_sr = instr[src_sr_lsb +: $bits(sr_idx_t)];
        end else begin
            src_sr = '0;
        end
    end

endmodule

//--- src/id_stage_latch.sv
`timescale 1ns/1ps

module id_stage_latch
    import isa_pkg::*;
    import decode_pkg::*;
#(
    parameter int pc_width = 24
) (
    input  logic                iw_clk,
    input  logic                iw_rst,
    input  logic                flush,
    input  logic                stall,
    input  logic [pc_width-1:0] pc_in,
    input  opc_t                opc_in,
    input  logic                sgn_en_in,
    input  logic                imm_en_in,
    input  logic                has_src_gp_in,
    input  logic                tgt_gp_we_in,
    input  logic                has_src_sr_in,
    input  logic                tgt_sr_we_in,
    input  imm10_t              imm10_in,
    input  imm12_t              imm12_in,
    input  imm14_t              imm14_in,
    input  imm16_t              imm16_in,
    input  cc_t                 cc_in,
    input  gp_idx_t             src_gp_in,
    input  gp_idx_t             tgt_gp_in,
    input  sr_idx_t             src_sr_in,
    input  sr_idx_t             tgt_sr_in,
    output logic [pc_width-1:0] pc,
    output opc_t                opc,
    output logic                sgn_en,
    output logic                imm_en,
    output logic                has_src_gp,
    output logic                tgt_gp_we,
    output logic                has_src_sr,
    output logic                tgt_sr_we,
    output imm10_t              imm10,
    output imm12_t              imm12,
    output imm14_t              imm14,
    output imm16_t              imm16,
    output cc_t                 cc,
    output gp_idx_t             src_gp,
    output gp_idx_t             tgt_gp,
    output sr_idx_t             src_sr,
    output sr_idx_t             tgt_sr
);

    // Six single-bit flags plus the typed fields
    localparam int bank_width = pc_width + $bits(opc_t) + 6 +
                                $bits(imm10_t) + $bits(imm12_t) +
                                $bits(imm14_t) + $bits(imm16_t) + $bits(cc_t) +
                                2 * $bits(gp_idx_t) + 2 * $bits(sr_idx_t);

    logic [bank_width-1:0] bank_d;
    logic [bank_width-1:0] bank_q;

    assign bank_d = {pc_in, opc_in, sgn_en_in, imm_en_in, has_src_gp_in,
                     tgt_gp_we_in, has_src_sr_in, tgt_sr_we_in,
                     imm10_in, imm12_in, imm14_in, imm16_in, cc_in,
                     src_gp_in, tgt_gp_in, src_sr_in, tgt_sr_in};

    // Flush wins over stall, a flushed slot is a bubble with all enables low
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            bank_q <= '0;
        end else if (flush) begin
            bank_q <= '0;
        end else if (!stall) begin
            bank_q <= bank_d;
        end
    end

    assign {pc, opc, sgn_en, imm_en, has_src_gp, tgt_gp_we, has_src_sr, tgt_sr_we,
            imm10, imm12, imm14, imm16, cc,
            src_gp, tgt_gp, src_sr, tgt_sr} = bank_q;

endmodule

//--- src/stg_id.sv
`timescale 1ns/1ps

module stg_id
    import isa_pkg::*;
    import decode_pkg::*;
#(
    parameter int pc_width = 24
) (
    input  logic                iw_clk,
    input  logic                iw_rst,
    input  logic [pc_width-1:0] pc,
    input  instr_t              instr,
    input  logic                flush,
    input  logic                stall,
    output logic [pc_width-1:0] pc_q,
    output opc_t                opc,
    output logic                sgn_en,
    output logic                imm_en,
    output imm10_t              imm10,
    output imm12_t              imm12,
    output imm14_t              imm14,
    output imm16_t              imm16,
    output cc_t                 cc,
    output logic                has_src_gp,
    output gp_idx_t             src_gp,
    output gp_idx_t             tgt_gp,
    output logic                tgt_gp_we,
    output logic                has_src_sr,
    output sr_idx_t             src_sr,
    output sr_idx_t             tgt_sr,
    output logic                tgt_sr_we
);

    // Classifier flags
    logic sgn_en_d;
    logic imm_en_d;
    logic has_src_gp_d;
    logic has_tgt_gp_d;
    logic tgt_gp_we_d;
    logic has_src_sr_d;
    logic has_tgt_sr_d;
    logic tgt_sr_we_d;
    logic uses_flags_d;

    // Extracted fields
    imm10_t  imm10_d;
    imm12_t  imm12_d;
    imm14_t  imm14_d;
    imm16_t  imm16_d;
    cc_t     cc_d;
    gp_idx_t src_gp_d;
    gp_idx_t tgt_gp_d;
    sr_idx_t src_sr_d;
    sr_idx_t tgt_sr_d;

    id_opcode_classify u_classify (
        .instr      (instr),
        .sgn_en     (sgn_en_d),
        .imm_en     (imm_en_d),
        .has_src_gp (has_src_gp_d),
        .has_tgt_gp (has_tgt_gp_d),
        .tgt_gp_we  (tgt_gp_we_d),
        .has_src_sr (has_src_sr_d),
        .has_tgt_sr (has_tgt_sr_d),
        .tgt_sr_we  (tgt_sr_we_d),
        .uses_flags (uses_flags_d)
    );

    id_field_extract u_extract (
        .instr      (instr),
        .has_src_gp (has_src_gp_d),
        .has_tgt_gp (has_tgt_gp_d),
        .has_src_sr (has_src_sr_d),
        .has_tgt_sr (has_tgt_sr_d),
        .uses_flags (uses_flags_d),
        .imm10      (imm10_d),
        .imm12      (imm12_d),
        .imm14      (imm14_d),
        .imm16      (imm16_d),
        .cc         (cc_d),
        .src_gp     (src_gp_d),
        .tgt_gp     (tgt_gp_d),
        .src_sr     (src_sr_d),
        .tgt_sr     (tgt_sr_d)
    );

    id_stage_latch #(
        .pc_width (pc_width)
    ) u_latch (
        .iw_clk        (iw_clk),
        .iw_rst        (iw_rst),
        .flush         (flush),
        .stall         (stall),
        .pc_in         (pc),
        .opc_in        (instr[opc_lsb +: $bits(opc_t)]),
        .sgn_en_in     (sgn_en_d),
        .imm_en_in     (imm_en_d),
        .has_src_gp_in (has_src_gp_d),
        .tgt_gp_we_in  (tgt_gp_we_d),
        .has_src_sr_in (has_src_sr_d),
        .tgt_sr_we_in  (tgt_sr_we_d),
        .imm10_in      (imm10_d),
        .imm12_in      (imm12_d),
        .imm14_in      (imm14_d),
        .imm16_in      (imm16_d),
        .cc_in         (cc_d),
        .src_gp_in     (src_gp_d),
        .tgt_gp_in     (tgt_gp_d),
        .src_sr_in     (src_sr_d),
        .tgt_sr_in     (tgt_sr_d),
        .pc            (pc_q),
        .opc           (opc),
        .sgn_en        (sgn_en),
        .imm_en        (imm_en),
        .has_src_gp    (has_src_gp),
        .tgt_gp_we     (tgt_gp_we),
        .has_src_sr    (has_src_sr),
        .tgt_sr_we     (tgt_sr_we),
        .imm10         (imm10),
        .imm12         (imm12),
        .imm14         (imm14),
        .imm16         (imm16),
        .cc            (cc),
        .src_gp        (src_gp),
        .tgt_gp        (tgt_gp),
        .src_sr        (src_sr),
        .tgt_sr        (tgt_sr)
    );

endmodule

//--- dv/stg_id_properties.sv
`timescale 1ns/1ps

module stg_id_properties
    import isa_pkg::*;
    import decode_pkg::*;
#(
    parameter int pc_width = 24
) (
    input logic                iw_clk,
    input logic                iw_rst,
    input logic                flush,
    input logic                stall,
    input logic [pc_width-1:0] pc_q,
    input opc_t                opc,
    input logic                sgn_en,
    input logic                imm_en,
    input imm10_t              imm10,
    input imm12_t              imm12,
    input imm14_t              imm14,
    input imm16_t              imm16,
    input cc_t                 cc,
    input logic                has_src_gp,
    input gp_idx_t             src_gp,
    input gp_idx_t             tgt_gp,
    input logic                tgt_gp_we,
    input logic                has_src_sr,
    input sr_idx_t             src_sr,
    input sr_idx_t             tgt_sr,
    input logic                tgt_sr_we
);

    localparam int outs_width = pc_width + $bits(opc_t) + 6 +
                                $bits(imm10_t) + $bits(imm12_t) +
                                $bits(imm14_t) + $bits(imm16_t) + $bits(cc_t) +
                                2 * $bits(gp_idx_t) + 2 * $bits(sr_idx_t);

    logic [outs_width-1:0] outs;

    // Whole visible state of the stage
    assign outs = {pc_q, opc, sgn_en, imm_en, imm10, imm12, imm14, imm16, cc,
                   has_src_gp, src_gp, tgt_gp, tgt_gp_we,
                   has_src_sr, src_sr, tgt_sr, tgt_sr_we};

    a_flush_clears: assert property (@(posedge iw_clk) disable iff (iw_rst)
        flush |=> (outs == '0))
        else $error("outputs not cleared one cycle after flush");

    a_stall_holds: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (stall && !flush) |=> $stable(outs))
        else $error("outputs changed while stalled");

    // Only one immediate width is ever selected
    a_one_imm: assert property (@(posedge iw_clk) disable iff (iw_rst)
        $onehot0({|imm10, |imm12, |imm14, |imm16}))
        else $error("more than one immediate output is nonzero");

endmodule

bind stg_id stg_id_properties #(.pc_width(pc_width)) u_stg_id_properties (.*);

//--- dv/tb_stg_id.sv
`timescale 1ns/1ps

module tb_stg_id
    import isa_pkg::*;
    import decode_pkg::*;
();

    localparam int clk_half    = 4;
    localparam int drive_delay = 1;
    localparam int wait_limit  = 16;

    logic    iw_clk;
    logic    iw_rst;
    pc_t     pc;
    instr_t  instr;
    logic    flush;
    logic    stall;
    pc_t     pc_q;
    opc_t    opc;
    logic    sgn_en;
    logic    imm_en;
    imm10_t  imm10;
    imm12_t  imm12;
    imm14_t  imm14;
    imm16_t  imm16;
    cc_t     cc;
    logic    has_src_gp;
    gp_idx_t src_gp;
    gp_idx_t tgt_gp;
    logic    tgt_gp_we;
    logic    has_src_sr;
    sr_idx_t src_sr;
    sr_idx_t tgt_sr;
    logic    tgt_sr_we;

    // Expected outputs from the reference decode
    pc_t     exp_pc;
    opc_t    exp_opc;
    logic    exp_sgn_en;
    logic    exp_imm_en;
    imm10_t  exp_imm10;
    imm12_t  exp_imm12;
    imm14_t  exp_imm14;
    imm16_t  exp_imm16;
    cc_t     exp_cc;
    logic    exp_has_src_gp;
    gp_idx_t exp_src_gp;
    gp_idx_t exp_tgt_gp;
    logic    exp_tgt_gp_we;
    logic    exp_has_src_sr;
    sr_idx_t exp_src_sr;
    sr_idx_t exp_tgt_sr;
    logic    exp_tgt_sr_we;

    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests_run = 0;
    logic [31:0] lcg_state = 32'he812;

    stg_id u_stg_id (.*);

    initial begin
        iw_clk = 1'b0;
        forever begin
            #clk_half iw_clk = ~iw_clk;
        end
    end

    always @(posedge iw_clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Polls on odd offsets from edge+1ns until the next edge+1ns
    task automatic wait_cycle();
        int start_count;
        int polls;
        start_count = cycle_count;
        polls = 0;
        while ((cycle_count == start_count) && (polls < wait_limit)) begin
            #2;
            polls++;
        end
        if (cycle_count == start_count) begin
            $display("Timeout: no rising clock edge within %0d ns", polls * 2);
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic tally_check(input string what, input logic ok,
                               input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (!ok) begin
            errors++;
            $display("ERROR @%0t: %s got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(input string what, input pc_t got, input pc_t exp);
        tally_check(what, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_opc(input string what, input opc_t got, input opc_t exp);
        tally_check(what, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        tally_check(what, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_imm10(input string what, input imm10_t got, input imm10_t exp);
        tally_check(what, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_imm12(input string what, input imm12_t got, input imm12_t exp);
        tally_check(what, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_imm14(input string what, input imm14_t got, input imm14_t exp);
        tally_check(what, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_imm16(input string what, input imm16_t got, input imm16_t exp);
        tally_check(what, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_cc(input string what, input cc_t got, input cc_t exp);
        tally_check(what, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_gp(input string what, input gp_idx_t got, input gp_idx_t exp);
        tally_check(what, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_sr(input string what, input sr_idx_t got, input sr_idx_t exp);
        tally_check(what, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_outputs(input string tag);
        check_pc({tag, " pc_q"}, pc_q, exp_pc);
        check_opc({tag, " opc"}, opc, exp_opc);
        check_flag({tag, " sgn_en"}, sgn_en, exp_sgn_en);
        check_flag({tag, " imm_en"}, imm_en, exp_imm_en);
        check_flag({tag, " has_src_gp"}, has_src_gp, exp_has_src_gp);
        check_flag({tag, " tgt_gp_we"}, tgt_gp_we, exp_tgt_gp_we);
        check_flag({tag, " has_src_sr"}, has_src_sr, exp_has_src_sr);
        check_flag({tag, " tgt_sr_we"}, tgt_sr_we, exp_tgt_sr_we);
        check_imm10({tag, " imm10"}, imm10, exp_imm10);
        check_imm12({tag, " imm12"}, imm12, exp_imm12);
        check_imm14({tag, " imm14"}, imm14, exp_imm14);
        check_imm16({tag, " imm16"}, imm16, exp_imm16);
        check_cc({tag, " cc"}, cc, exp_cc);
        check_gp({tag, " src_gp"}, src_gp, exp_src_gp);
        check_gp({tag, " tgt_gp"}, tgt_gp, exp_tgt_gp);
        check_sr({tag, " src_sr"}, src_sr, exp_src_sr);
        check_sr({tag, " tgt_sr"}, tgt_sr, exp_tgt_sr);
    endtask

    task automatic clear_expected();
        exp_pc         = '0;
        exp_opc        = '0;
        exp_sgn_en     = 1'b0;
        exp_imm_en     = 1'b0;
        exp_imm10      = '0;
        exp_imm12      = '0;
        exp_imm14      = '0;
        exp_imm16      = '0;
        exp_cc         = '0;
        exp_has_src_gp = 1'b0;
        exp_src_gp     = '0;
        exp_tgt_gp     = '0;
        exp_tgt_gp_we  = 1'b0;
        exp_has_src_sr = 1'b0;
        exp_src_sr     = '0;
        exp_tgt_sr     = '0;
        exp_tgt_sr_we  = 1'b0;
    endtask

    // Reference decode written from the ISA operand rules
    task automatic model_decode(input instr_t i, input pc_t p);
        opc_t     op;
        opclass_t cls;
        logic     flags_rd;
        logic     cmp_tst;
        logic     has_tgt_gp;
        logic     has_tgt_sr;
        op  = i[23:16];
        cls = i[23:20];
        clear_expected();
        exp_pc   = p;
        exp_opc  = op;
        flags_rd = (cls == opclass_br) || (op == opc_sr_jcc_so);
        cmp_tst  = op inside {opc_cmp_ur, opc_tst_ur, opc_cmp_ui, opc_cmp_sr, opc_tst_sr,
                              opc_cmp_si};
        exp_sgn_en = (cls == opclass_sr) || (cls == opclass_si) ||
                     (op inside {opc_bcc_sr, opc_bcc_so, opc_bal_so, opc_sr_jcc_so,
                                 opc_sr_add_si, opc_sr_sub_si, opc_sr_st_so, opc_sr_ld_so});
        exp_imm_en = (cls == opclass_ui) || (cls == opclass_si) ||
                     (op inside {opc_jcc_ui, opc_bcc_so, opc_bal_so, opc_sr_jcc_so,
                                 opc_sr_add_si, opc_sr_sub_si, opc_sr_st_so, opc_sr_ld_so,
                                 opc_syscall});
        // Classes 0 to 3 are the ALU classes
        exp_tgt_gp_we  = ((cls <= opclass_si) && !cmp_tst) ||
                         (op inside {opc_mcc_ur, opc_mcc_si});
        has_tgt_gp     = exp_tgt_gp_we || cmp_tst || (op == opc_bcc_sr);
        exp_has_src_gp = ((cls == opclass_ur) && !(op inside {opc_not_ur, opc_tst_ur})) ||
                         (op inside {opc_add_sr, opc_sub_sr, opc_shr_sr, opc_cmp_sr,
                                     opc_mcc_ur});
        exp_tgt_sr_we  = op inside {opc_sr_mov_ur, opc_sr_add_si, opc_sr_sub_si,
                                    opc_sr_ld_so, opc_syscall};
        has_tgt_sr     = exp_tgt_sr_we || (op == opc_sr_st_so);
        exp_has_src_sr = flags_rd ||
                         (op inside {opc_sr_mov_ur, opc_sr_jcc_so, opc_sr_ld_so, opc_sr_st_so});
        if ((cls == opclass_ui) || (cls == opclass_si) ||
            (op inside {opc_jcc_ui, opc_bcc_so, opc_sr_st_so, opc_sr_ld_so, opc_syscall})) begin
            exp_imm12 = i[11:0];
        end else if (op inside {opc_sr_add_si, opc_sr_sub_si}) begin
            exp_imm14 = i[13:0];
        end else if (op == opc_sr_jcc_so) begin
            exp_imm10 = i[9:0];
        end else if (op == opc_bal_so) begin
            exp_imm16 = i[15:0];
        end
        case (op)
            opc_jcc_ui, opc_bcc_so: exp_cc = i[15:12];
            opc_bcc_sr, opc_mcc_si: exp_cc = i[11:8];
            opc_sr_jcc_so:          exp_cc = i[13:10];
            opc_mcc_ur:             exp_cc = i[7:4];
            default:                exp_cc = '0;
        endcase
        exp_tgt_gp = has_tgt_gp ? i[15:12] : '0;
        exp_src_gp = exp_has_src_gp ? i[11:8] : '0;
        exp_tgt_sr = (op inside {opc_syscall, opc_kret}) ? sr_idx_lr :
                     (has_tgt_sr ? i[15:14] : '0);
        exp_src_sr = flags_rd ? sr_idx_fl : (exp_has_src_sr ? i[13:12] : '0);
    endtask

    task automatic drive_instr(input opc_t op);
        logic [31:0] r;
        r     = lcg_next();
        instr = {op, r[15:0]};
        pc    = pc_t'(lcg_next());
    endtask

    // Result of a one-cycle latency shows at the next drive point
    task automatic issue_and_check(input opc_t op, input string tag);
        drive_instr(op);
        model_decode(instr, pc);
        wait_cycle();
        check_outputs(tag);
    endtask

    task automatic run_opcodes(input string name, input opc_t ops[$], input int reps);
        foreach (ops[k]) begin
            repeat (reps) begin
                issue_and_check(ops[k], $sformatf("%s opc %02h", name, ops[k]));
            end
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        $display("Test %s done, %0d errors", name, errors - err_before);
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        clear_expected();
        check_outputs("reset");
        repeat (15) begin
            drive_instr(opc_t'(lcg_next()));
            wait_cycle();
            check_outputs("reset");
        end
        iw_rst = 1'b0;
        // First edge after release loads the decoded instruction
        issue_and_check(opc_add_ur, "after reset");
        finish_test("reset", err0);
    endtask

    task automatic test_reg_alu();
        int   err0;
        opc_t ops[$] = '{opc_mov_ur, opc_add_ur, opc_sub_ur, opc_not_ur, opc_and_ur,
                         opc_or_ur, opc_xor_ur, opc_shl_ur, opc_shr_ur, opc_rol_ur,
                         opc_ror_ur, opc_cmp_ur, opc_tst_ur, opc_add_sr, opc_sub_sr,
                         opc_shr_sr, opc_neg_sr, opc_cmp_sr, opc_tst_sr};
        err0 = errors;
        run_opcodes("reg_alu", ops, 2);
        finish_test("reg_alu", err0);
    endtask

    task automatic test_imm_alu();
        int   err0;
        opc_t ops[$] = '{opc_mov_ui, opc_add_ui, opc_sub_ui, opc_and_ui, opc_or_ui,
                         opc_xor_ui, opc_shl_ui, opc_shr_ui, opc_rol_ui, opc_ror_ui,
                         opc_cmp_ui, opc_lui_ui, opc_mov_si, opc_add_si, opc_sub_si,
                         opc_shr_si, opc_cmp_si};
        err0 = errors;
        run_opcodes("imm_alu", ops, 2);
        finish_test("imm_alu", err0);
    endtask

    task automatic test_branch();
        int   err0;
        opc_t ops[$] = '{opc_jcc_ui, opc_bcc_sr, opc_bcc_so, opc_bal_so, opc_mcc_ur,
                         opc_mcc_si};
        err0 = errors;
        run_opcodes("branch", ops, 3);
        finish_test("branch", err0);
    endtask

    task automatic test_special();
        int   err0;
        opc_t ops[$] = '{opc_sr_mov_ur, opc_sr_jcc_so, opc_sr_add_si, opc_sr_sub_si,
                         opc_sr_st_so, opc_sr_ld_so, opc_syscall, opc_kret};
        err0 = errors;
        run_opcodes("special", ops, 3);
        finish_test("special", err0);
    endtask

    task automatic test_stall_flush();
        int err0;
        err0 = errors;
        issue_and_check(opc_add_ui, "stall setup");
        // Upstream keeps changing while the stage holds
        stall = 1'b1;
        repeat (3) begin
            drive_instr(opc_sr_sub_si);
            wait_cycle();
            check_outputs("stall hold");
        end
        flush = 1'b1;
        drive_instr(opc_mcc_si);
        clear_expected();
        wait_cycle();
        check_outputs("flush with stall");
        flush = 1'b0;
        drive_instr(opc_syscall);
        wait_cycle();
        check_outputs("stall after flush");
        // Held instruction enters one cycle after release
        stall = 1'b0;
        model_decode(instr, pc);
        wait_cycle();
        check_outputs("stall release");
        issue_and_check(opc_bal_so, "after release");
        finish_test("stall_flush", err0);
    endtask

    initial begin
        iw_rst = 1'b1;
        flush  = 1'b0;
        stall  = 1'b0;
        instr  = '0;
        pc     = '0;
        #(clk_half + drive_delay);
        test_reset();
        test_reg_alu();
        test_imm_alu();
        test_branch();
        test_special();
        test_stall_flush();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- project.f
src/decode_pkg.sv
src/isa_pkg.sv
src/id_opcode_classify.sv
src/id_field_extract.sv
src/id_stage_latch.sv
src/stg_id.sv
dv/stg_id_properties.sv
dv/tb_stg_id.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_stg_id
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  := ** FAIL **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
